// ==== rtl/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

    // cache geometry
    localparam int LEN_LINE  = 6;
    localparam int LEN_INDEX = 6;
    localparam int NR_WAYS   = 2;
    localparam int LEN_TAG   = 20;
    localparam int NR_WORDS  = 16;
    localparam int NR_LINES  = 64;

    // answer of the L2 TLB for one even/odd page pair
    typedef struct packed {
        logic [18:0]        vpn2;
        logic [LEN_TAG-1:0] pfn0;
        logic [LEN_TAG-1:0] pfn1;
        logic               v0;
        logic               v1;
        logic               c0;
        logic               c1;
    } tlb_entry;

    typedef enum logic [2:0] {
        idle,
        tlb_fill,
        uncached,
        cache_replace,
        save_result
    } icache_state_e;

endpackage

`default_nettype wire

// ==== rtl/icache_ifs.sv ====
`default_nettype none

// translation result of the L1 TLB plus its control from the FSM
interface translate_if import icache_pkg::*; ();
    logic [LEN_TAG-1:0] pa_tag;
    logic               uncached;
    logic               translation_ok;
    logic [31:12]       vpn;
    logic               fill_en;
    logic               inv;

    modport tlb (
        output pa_tag, uncached, translation_ok, vpn,
        input  fill_en, inv
    );
    modport ctrl (
        input  pa_tag, uncached, translation_ok, vpn,
        output fill_en, inv
    );
    modport user (
        input  pa_tag
    );
endinterface

// line refill writes from the FSM into tag and data arrays
interface refill_if import icache_pkg::*; ();
    logic                 way;
    logic [LEN_INDEX-1:0] line_addr;
    logic [LEN_LINE-3:0]  beat;
    logic [31:0]          wdata;
    logic                 data_we;
    logic                 tag_we;
    logic                 set_valid;

    modport ctrl (
        output way, line_addr, beat, wdata, data_we, tag_we, set_valid
    );
    modport array (
        input  way, line_addr, beat, wdata, data_we, tag_we, set_valid
    );
endinterface

`default_nettype wire

// ==== rtl/itlb_l1.sv ====
`default_nettype none

module itlb_l1 import icache_pkg::*; (
    input  wire           clk,
    input  wire           rst,
    input  wire    [31:0] inst_va,
    input  wire tlb_entry itlb_entry,
    translate_if.tlb      tr
);

    logic [31:12]       ent_vpn;
    logic [LEN_TAG-1:0] ent_pfn;
    logic               ent_uncached;
    logic               ent_valid;
    logic               direct_mapped;

    // kseg0 and kseg1 skip translation
    assign direct_mapped = inst_va[31:30] == 2'b10;

    assign tr.vpn = inst_va[31:12];

    // va bit 29 separates kseg1 (uncached) from kseg0
    assign tr.uncached = direct_mapped ? inst_va[29] : ent_uncached;
    assign tr.pa_tag   = direct_mapped ? {3'b000, inst_va[28:12]} : ent_pfn;

    assign tr.translation_ok = direct_mapped ||
                               (ent_valid && ent_vpn == inst_va[31:12]);

    always_ff @(posedge clk) begin
        if (rst) begin
            ent_vpn      <= '0;
            ent_pfn      <= '0;
            ent_uncached <= 1'b0;
            ent_valid    <= 1'b0;
        end else begin
            if (tr.inv) begin
                ent_valid <= 1'b0;
            end
            // even or odd page of the pair
            if (tr.fill_en) begin
                ent_vpn      <= inst_va[31:12];
                ent_pfn      <= inst_va[12] ? itlb_entry.pfn1 : itlb_entry.pfn0;
                ent_uncached <= inst_va[12] ? !itlb_entry.c1 : !itlb_entry.c0;
                ent_valid    <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/icache_tag_array.sv ====
`default_nettype none

module icache_tag_array import icache_pkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire [31:0] inst_va,
    input  wire [31:0] inst_va_next,
    input  wire        ram_sel,
    input  wire        fence_i,
    input  wire [31:0] fence_addr,
    input  wire        fence_ok,
    input  wire        lru_update,
    output logic       hit,
    output logic       hit_way,
    output logic       lru_way,
    translate_if.user  tr,
    refill_if.array    rf
);

    logic [LEN_TAG-1:0]   tag_mem [NR_WAYS][NR_LINES];
    logic [LEN_TAG-1:0]   tag_q [NR_WAYS];
    logic [NR_WAYS-1:0]   valid [NR_LINES];
    logic                 lru [NR_LINES];
    logic [LEN_INDEX-1:0] va_index;
    logic [LEN_INDEX-1:0] rd_index;
    logic [LEN_INDEX-1:0] fence_index;
    logic [NR_WAYS-1:0]   way_match;

    assign va_index    = inst_va[LEN_LINE+LEN_INDEX-1:LEN_LINE];
    assign fence_index = fence_addr[LEN_LINE+LEN_INDEX-1:LEN_LINE];

    // next address is read ahead so a hit answers in the same cycle
    assign rd_index = ram_sel ? va_index : inst_va_next[LEN_LINE+LEN_INDEX-1:LEN_LINE];

    always_ff @(posedge clk) begin
        for (int w = 0; w < NR_WAYS; w++) begin
            if (rf.tag_we && rf.way == 1'(w)) begin
                tag_mem[w][rf.line_addr] <= tr.pa_tag;
            end
            tag_q[w] <= tag_mem[w][rd_index];
        end
    end

    always_comb begin
        for (int w = 0; w < NR_WAYS; w++) begin
            way_match[w] = valid[va_index][w] && tag_q[w] == tr.pa_tag;
        end
    end

    assign hit = |way_match;
    // with two ways the match of way 1 is the way number
    assign hit_way = way_match[1];
    assign lru_way = lru[va_index];

    // valid and LRU metadata
    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '{default: '0};
            lru   <= '{default: 1'b0};
        end else begin
            if (fence_i && fence_ok) begin
                valid[fence_index] <= '0;
            end
            // line is invalid while it refills
            if (rf.tag_we) begin
                valid[rf.line_addr][rf.way] <= 1'b0;
            end
            if (rf.set_valid) begin
                valid[rf.line_addr][rf.way] <= 1'b1;
            end
            // point at the way not just used
            if (lru_update) begin
                lru[va_index] <= ~rf.way;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/icache_data_array.sv ====
`default_nettype none

module icache_data_array import icache_pkg::*; (
    input  wire         clk,
    input  wire  [31:0] inst_va,
    input  wire  [31:0] inst_va_next,
    input  wire         ram_sel,
    input  wire         hit_way,
    output logic [31:0] inst_rdata0,
    output logic [31:0] inst_rdata1,
    refill_if.array     rf
);

    logic [63:0]                   mem [NR_WAYS][NR_LINES*NR_WORDS/2];
    logic [63:0]                   rd_q [NR_WAYS];
    logic [LEN_INDEX+LEN_LINE-4:0] rd_addr;
    logic [LEN_INDEX+LEN_LINE-4:0] wr_addr;
    logic [63:0]                   sel_word;

    assign rd_addr = ram_sel ? inst_va[LEN_INDEX+LEN_LINE-1:3]
                             : inst_va_next[LEN_INDEX+LEN_LINE-1:3];

    // two beats per 64-bit word
    assign wr_addr = {rf.line_addr, rf.beat[LEN_LINE-3:1]};

    always_ff @(posedge clk) begin
        for (int w = 0; w < NR_WAYS; w++) begin
            if (rf.data_we && rf.way == 1'(w)) begin
                if (rf.beat[0]) begin
                    mem[w][wr_addr][63:32] <= rf.wdata;
                end else begin
                    mem[w][wr_addr][31:0] <= rf.wdata;
                end
            end
            rd_q[w] <= mem[w][rd_addr];
        end
    end

    assign sel_word = rd_q[hit_way];

    // second instruction only exists for an even word
    assign inst_rdata0 = inst_va[2] ? sel_word[63:32] : sel_word[31:0];
    assign inst_rdata1 = sel_word[63:32];

endmodule

`default_nettype wire

// ==== rtl/icache_ctrl.sv ====
`default_nettype none

module icache_ctrl import icache_pkg::*; (
    input  wire           clk,
    input  wire           rst,
    input  wire           inst_en,
    input  wire    [31:0] inst_va,
    input  wire           stallF,
    input  wire           fence_tlb,
    input  wire           itlb_found,
    input  wire tlb_entry itlb_entry,
    input  wire           hit,
    input  wire           hit_way,
    input  wire           lru_way,
    input  wire    [31:0] inst_rdata0,
    input  wire    [31:0] inst_rdata1,
    input  wire           arready,
    input  wire    [31:0] rdata,
    input  wire           rlast,
    input  wire           rvalid,
    output logic          inst_ok0,
    output logic          inst_ok1,
    output logic   [31:0] rdata0,
    output logic   [31:0] rdata1,
    output logic          inst_tlb_refill,
    output logic          inst_tlb_invalid,
    output logic          istall,
    output logic  [31:13] itlb_vpn2,
    output logic   [31:0] araddr,
    output logic    [7:0] arlen,
    output logic    [2:0] arsize,
    output logic          arvalid,
    output logic          rready,
    output logic          ram_sel,
    output logic          fence_ok,
    output logic          lru_update,
    translate_if.ctrl     tr,
    refill_if.ctrl        rf
);

    icache_state_e        state;
    logic                 hit_ok;
    logic                 page_valid;
    logic                 beat_ok;
    logic                 tag_we_q;
    logic                 way_q;
    logic                 saved_ok0;
    logic [31:0]          saved_rdata0;
    logic [LEN_LINE-3:0]  beat_cnt;
    logic [LEN_INDEX-1:0] line_q;

    assign hit_ok  = hit && tr.translation_ok && !tr.uncached;
    assign beat_ok = rvalid && rready;

    assign istall = (state == idle) ? (inst_en && !hit_ok) : (state != save_result);

    // fences wait for a quiet pipeline
    assign fence_ok   = !istall && !stallF;
    assign tr.inv     = fence_tlb && fence_ok;
    assign lru_update = state == idle && inst_en && hit_ok && !stallF;

    // RAMs take the current address while a miss is served
    assign ram_sel = state != idle && state != save_result;

    assign inst_ok0 = (state == idle ? hit_ok : saved_ok0) && inst_en;
    assign inst_ok1 = state == idle && hit_ok && !inst_va[2] && inst_en;
    assign rdata0   = state == idle ? inst_rdata0 : saved_rdata0;
    assign rdata1   = state == idle ? inst_rdata1 : '0;

    assign page_valid = tr.vpn[12] ? itlb_entry.v1 : itlb_entry.v0;
    assign tr.fill_en = state == tlb_fill && itlb_found && page_valid;

    // in idle the way port carries the hit way for the LRU update
    assign rf.way       = state == idle ? hit_way : way_q;
    assign rf.line_addr = line_q;
    assign rf.beat      = beat_cnt;
    assign rf.wdata     = rdata;
    assign rf.data_we   = state == cache_replace && beat_ok;
    assign rf.tag_we    = tag_we_q;
    assign rf.set_valid = rf.data_we && rlast;

    always_ff @(posedge clk) begin
        if (rst) begin
            state            <= idle;
            arvalid          <= 1'b0;
            rready           <= 1'b0;
            tag_we_q         <= 1'b0;
            beat_cnt         <= '0;
            saved_ok0        <= 1'b0;
            inst_tlb_refill  <= 1'b0;
            inst_tlb_invalid <= 1'b0;
        end else begin
            tag_we_q <= 1'b0;
            case (state)
                idle: begin
                    if (inst_en) begin
                        if (!tr.translation_ok) begin
                            itlb_vpn2 <= tr.vpn[31:13];
                            state     <= tlb_fill;
                        end else if (tr.uncached) begin
                            araddr  <= {tr.pa_tag, inst_va[11:0]};
                            arlen   <= 8'd0;
                            arsize  <= 3'd2;
                            arvalid <= 1'b1;
                            state   <= uncached;
                        end else if (!hit) begin
                            // line aligned burst into the LRU way
                            araddr   <= {tr.pa_tag, inst_va[LEN_LINE+LEN_INDEX-1:LEN_LINE],
                                         {LEN_LINE{1'b0}}};
                            arlen    <= 8'(NR_WORDS - 1);
                            arsize   <= 3'd2;
                            arvalid  <= 1'b1;
                            way_q    <= lru_way;
                            line_q   <= inst_va[LEN_LINE+LEN_INDEX-1:LEN_LINE];
                            tag_we_q <= 1'b1;
                            beat_cnt <= '0;
                            state    <= cache_replace;
                        end
                    end
                end
                tlb_fill: begin
                    if (itlb_found && page_valid) begin
                        state <= idle;
                    end else begin
                        inst_tlb_invalid <= itlb_found;
                        inst_tlb_refill  <= !itlb_found;
                        saved_rdata0     <= '0;
                        saved_ok0        <= 1'b0;
                        state            <= save_result;
                    end
                end
                uncached: begin
                    if (arvalid) begin
                        if (arready) begin
                            arvalid <= 1'b0;
                            rready  <= 1'b1;
                        end
                    end else if (beat_ok) begin
                        saved_rdata0 <= rdata;
                        saved_ok0    <= 1'b1;
                        rready       <= 1'b0;
                        state        <= save_result;
                    end
                end
                cache_replace: begin
                    if (arvalid) begin
                        if (arready) begin
                            arvalid <= 1'b0;
                            rready  <= 1'b1;
                        end
                    end else if (beat_ok) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (rlast) begin
                            rready <= 1'b0;
                        end
                    end else if (!rready) begin
                        // last beat is in the RAM now
                        state <= idle;
                    end
                end
                save_result: begin
                    if (!stallF) begin
                        inst_tlb_refill  <= 1'b0;
                        inst_tlb_invalid <= 1'b0;
                        saved_ok0        <= 1'b0;
                        state            <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/icache_top.sv ====
`default_nettype none

module icache_top import icache_pkg::*; (
    input  wire           clk,
    input  wire           rst,
    // fetch stage
    input  wire           inst_en,
    input  wire    [31:0] inst_va,
    input  wire    [31:0] inst_va_next,
    output logic   [31:0] inst_rdata0,
    output logic   [31:0] inst_rdata1,
    output logic          inst_ok0,
    output logic          inst_ok1,
    output logic          inst_tlb_refill,
    output logic          inst_tlb_invalid,
    input  wire           stallF,
    output logic          istall,
    input  wire           fence_i,
    input  wire    [31:0] fence_addr,
    input  wire           fence_tlb,
    // L2 TLB
    output logic  [31:13] itlb_vpn2,
    input  wire           itlb_found,
    input  wire tlb_entry itlb_entry,
    // AXI read channel
    output logic   [31:0] araddr,
    output logic    [7:0] arlen,
    output logic    [2:0] arsize,
    output logic          arvalid,
    input  wire           arready,
    input  wire    [31:0] rdata,
    input  wire           rlast,
    input  wire           rvalid,
    output logic          rready
);

    logic        hit;
    logic        hit_way;
    logic        lru_way;
    logic        ram_sel;
    logic        fence_ok;
    logic        lru_update;
    logic [31:0] cache_rdata0;
    logic [31:0] cache_rdata1;

    translate_if tr ();
    refill_if    rf ();

    itlb_l1 itlb_i (.*);

    icache_tag_array tag_i (.*);

    icache_data_array data_i (
        .*,
        .inst_rdata0 (cache_rdata0),
        .inst_rdata1 (cache_rdata1)
    );

    // cache words in, CPU words out
    icache_ctrl ctrl_i (
        .*,
        .inst_rdata0 (cache_rdata0),
        .inst_rdata1 (cache_rdata1),
        .rdata0      (inst_rdata0),
        .rdata1      (inst_rdata1)
    );

endmodule

`default_nettype wire

// ==== test/icache_mem_model.sv ====
`default_nettype none

module icache_mem_model import icache_pkg::*; (
    input  wire           clk,
    input  wire    [31:0] araddr,
    input  wire     [7:0] arlen,
    input  wire     [2:0] arsize,
    input  wire           arvalid,
    output logic          arready,
    output logic   [31:0] rdata,
    output logic          rlast,
    output logic          rvalid,
    input  wire           rready,
    input  wire   [31:13] itlb_vpn2,
    output logic          itlb_found,
    output tlb_entry      itlb_entry
);

    int          burst_count;
    logic [31:0] last_araddr;
    logic  [7:0] last_arlen;
    logic  [2:0] last_arsize;

    // L2 TLB table where V and C apply to both pages of a pair
    logic        tab_used [4];
    logic [18:0] tab_vpn2 [4];
    logic [19:0] tab_pfn0 [4];
    logic [19:0] tab_pfn1 [4];
    logic        tab_v [4];
    logic        tab_c [4];

    task automatic set_page(input int idx, input logic [18:0] vpn2, input logic [19:0] pfn0,
                            input logic [19:0] pfn1, input logic v, input logic c);
        tab_used[idx] = 1'b1;
        tab_vpn2[idx] = vpn2;
        tab_pfn0[idx] = pfn0;
        tab_pfn1[idx] = pfn1;
        tab_v[idx]    = v;
        tab_c[idx]    = c;
    endtask

    always_comb begin
        itlb_found = 1'b0;
        itlb_entry = '0;
        for (int i = 0; i < 4; i++) begin
            if (tab_used[i] && tab_vpn2[i] == itlb_vpn2) begin
                itlb_found = 1'b1;
                itlb_entry = '{vpn2: tab_vpn2[i], pfn0: tab_pfn0[i], pfn1: tab_pfn1[i],
                               v0: tab_v[i], v1: tab_v[i], c0: tab_c[i], c1: tab_c[i]};
            end
        end
    end

    // AXI read slave whose outputs change 1 unit after the edge
    initial begin
        logic [31:0] addr;
        logic  [7:0] len;
        burst_count = 0;
        last_araddr = '0;
        last_arlen  = '0;
        last_arsize = '0;
        arready = 1'b0;
        rvalid  = 1'b0;
        rlast   = 1'b0;
        rdata   = '0;
        for (int i = 0; i < 4; i++) begin
            tab_used[i] = 1'b0;
        end
        forever begin
            @(posedge clk);
            #1;
            if (arvalid) begin
                addr = araddr;
                len  = arlen;
                burst_count++;
                last_araddr = araddr;
                last_arlen  = arlen;
                last_arsize = arsize;
                repeat ($urandom % 3) begin
                    @(posedge clk);
                    #1;
                end
                arready = 1'b1;
                @(posedge clk);
                #1;
                arready = 1'b0;
                for (int b = 0; b <= int'(len); b++) begin
                    repeat ($urandom % 3) begin
                        @(posedge clk);
                        #1;
                    end
                    rvalid = 1'b1;
                    rdata  = (addr + 32'(4 * b)) ^ 32'h5a5a0000;
                    rlast  = b == int'(len);
                    @(posedge clk);
                    #1;
                    rvalid = 1'b0;
                    rlast  = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_icache.sv ====
`default_nettype none

module tb_icache import icache_pkg::*; ();

    logic        clk;
    logic        rst;
    logic        inst_en;
    logic [31:0] inst_va;
    logic [31:0] inst_va_next;
    logic [31:0] inst_rdata0;
    logic [31:0] inst_rdata1;
    logic        inst_ok0;
    logic        inst_ok1;
    logic        inst_tlb_refill;
    logic        inst_tlb_invalid;
    logic        stallF;
    logic        istall;
    logic        fence_i;
    logic [31:0] fence_addr;
    logic        fence_tlb;
    logic [31:13] itlb_vpn2;
    logic        itlb_found;
    tlb_entry    itlb_entry;
    logic [31:0] araddr;
    logic  [7:0] arlen;
    logic  [2:0] arsize;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic        rlast;
    logic        rvalid;
    logic        rready;

    int          errors;
    int          exp_bursts;
    logic [31:0] exp_rdata0;
    logic [31:0] exp_rdata1;
    logic        exp_ok0;
    logic        exp_ok1;
    logic        exp_refill;
    logic        exp_invalid;

    // reference cache state with two ways and one LRU bit per line
    logic        ref_valid [2][64];
    logic [19:0] ref_tag [2][64];
    logic        ref_lru [64];

    icache_top dut_i (.*);

    icache_mem_model mem_i (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("errors: %0d", errors + 1);
        $display("Test failed");
        $finish;
    endtask

    function automatic logic [31:0] model_word(input logic [31:0] pa);
        return {pa[31:2], 2'b00} ^ 32'h5a5a0000;
    endfunction

    // 0 cached, 1 uncached, 2 tlb refill, 3 tlb invalid
    function automatic int translate(input logic [31:0] va, output logic [31:0] pa);
        pa = '0;
        if (va[31:30] == 2'b10) begin
            pa = {3'b000, va[28:0]};
            return va[29] ? 1 : 0;
        end
        for (int i = 0; i < 4; i++) begin
            if (mem_i.tab_used[i] && mem_i.tab_vpn2[i] == va[31:13]) begin
                if (!mem_i.tab_v[i]) begin
                    return 3;
                end
                pa = {va[12] ? mem_i.tab_pfn1[i] : mem_i.tab_pfn0[i], va[11:0]};
                return mem_i.tab_c[i] ? 0 : 1;
            end
        end
        return 2;
    endfunction

    // returns 1 on a predicted miss and updates the ways
    function automatic logic ref_access(input logic [31:0] pa);
        logic [5:0] idx;
        logic       way;
        idx = pa[11:6];
        for (int w = 0; w < 2; w++) begin
            if (ref_valid[w][idx] && ref_tag[w][idx] == pa[31:12]) begin
                ref_lru[idx] = ~1'(w);
                return 1'b0;
            end
        end
        way = ref_lru[idx];
        ref_valid[way][idx] = 1'b1;
        ref_tag[way][idx]   = pa[31:12];
        ref_lru[idx]        = ~way;
        return 1'b1;
    endfunction

    // comparing process
    always @(negedge clk) begin
        if (!rst && inst_en && !istall) begin
            check("inst_ok0", 32'(inst_ok0), 32'(exp_ok0));
            check("inst_ok1", 32'(inst_ok1), 32'(exp_ok1));
            check("inst_rdata0", inst_rdata0, exp_rdata0);
            check("inst_rdata1", inst_rdata1, exp_rdata1);
            check("inst_tlb_refill", 32'(inst_tlb_refill), 32'(exp_refill));
            check("inst_tlb_invalid", 32'(inst_tlb_invalid), 32'(exp_invalid));
        end
    end

    task automatic fetch(input logic [31:0] va, input int hold);
        logic [31:0] pa;
        logic        burst;
        logic [7:0]  len;
        int          kind;
        int          cycles;
        kind  = translate(va, pa);
        burst = kind == 1 || (kind == 0 && ref_access(pa));
        len   = kind == 1 ? 8'd0 : 8'd15;
        exp_bursts += burst ? 1 : 0;
        exp_refill  = kind == 2;
        exp_invalid = kind == 3;
        exp_ok0     = kind < 2;
        exp_ok1     = kind == 0 && !va[2];
        exp_rdata0  = kind >= 2 ? 32'd0 : model_word(pa);
        exp_rdata1  = kind == 0 ? model_word({pa[31:3], 3'b100}) : 32'd0;
        @(posedge clk);
        #1;
        inst_va_next = va;
        @(posedge clk);
        #1;
        inst_va = va;
        inst_en = 1'b1;
        stallF  = hold > 0;
        cycles  = 0;
        @(negedge clk);
        while (istall && cycles < 400) begin
            @(negedge clk);
            cycles++;
        end
        if (istall) begin
            abort_run("timeout while waiting for a fetch to complete");
        end
        // outputs are compared every held cycle
        repeat (hold) @(negedge clk);
        if (hold > 0) begin
            @(posedge clk);
            #1;
            stallF = 1'b0;
        end
        @(posedge clk);
        #1;
        inst_en = 1'b0;
        check("burst count", 32'(mem_i.burst_count), 32'(exp_bursts));
        if (burst) begin
            check("araddr", mem_i.last_araddr, kind == 1 ? pa : {pa[31:6], 6'd0});
            check("arlen", 32'(mem_i.last_arlen), 32'(len));
            check("arsize", 32'(mem_i.last_arsize), 32'd2);
        end
    endtask

    task automatic pulse_fence(input logic tlb, input logic [31:0] addr);
        @(posedge clk);
        #1;
        fence_addr = addr;
        fence_i    = !tlb;
        fence_tlb  = tlb;
        @(posedge clk);
        #1;
        fence_i   = 1'b0;
        fence_tlb = 1'b0;
        if (!tlb) begin
            ref_valid[0][addr[11:6]] = 1'b0;
            ref_valid[1][addr[11:6]] = 1'b0;
        end
    endtask

    initial begin
        void'($urandom(64));
        errors       = 0;
        exp_bursts   = 0;
        rst          = 1'b1;
        inst_en      = 1'b0;
        inst_va      = '0;
        inst_va_next = '0;
        stallF       = 1'b0;
        fence_i      = 1'b0;
        fence_addr   = '0;
        fence_tlb    = 1'b0;
        for (int i = 0; i < 64; i++) begin
            ref_valid[0][i] = 1'b0;
            ref_valid[1][i] = 1'b0;
            ref_lru[i]      = 1'b0;
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        // cached miss and then hits on the whole line
        for (int i = 0; i < 16; i++) begin
            fetch(32'h8000_1000 + 32'(4 * i), 0);
        end
        // uncached fetches repeat their burst
        fetch(32'ha000_2004, 0);
        fetch(32'ha000_2004, 0);
        // translated pages
        mem_i.set_page(0, 19'h200, 20'h00123, 20'h00124, 1'b1, 1'b1);
        mem_i.set_page(1, 19'h300, 20'h00555, 20'h00556, 1'b0, 1'b1);
        fetch(32'h0040_0010, 0);
        fetch(32'h0040_1008, 0);
        fetch(32'h0060_0000, 0);
        fetch(32'h0100_0000, 0);
        // LRU order A B A C B on index 5
        fetch(32'h8000_0140, 0);
        fetch(32'h8000_1140, 0);
        fetch(32'h8000_0140, 0);
        fetch(32'h8000_2140, 0);
        fetch(32'h8000_1140, 0);
        // fences
        pulse_fence(1'b0, 32'h8000_0140);
        fetch(32'h8000_0140, 0);
        fetch(32'h0040_0010, 0);
        pulse_fence(1'b1, 32'h0);
        mem_i.set_page(0, 19'h200, 20'h00200, 20'h00124, 1'b1, 1'b1);
        fetch(32'h0040_0010, 0);
        // stallF holds save_result
        fetch(32'ha000_3000, 4);
        fetch(32'h0100_0000, 3);

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
rtl/icache_pkg.sv
rtl/icache_ifs.sv
rtl/itlb_l1.sv
rtl/icache_tag_array.sv
rtl/icache_data_array.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
test/icache_mem_model.sv
test/tb_icache.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert
TOP       := tb_icache
FILELIST  := build.f
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
